/* sim/soc_bus_stimulus.txt */
# name rw address wdata exp_rdata exp_error exp_led, all numbers in hex
# rw 1 is a write, exp_led is the LED value when the response arrives
ram_wr0 1 00010000 12345678 00000000 0 000
ram_rd0 0 00010000 00000000 12345678 0 000
ram_wr_a 1 00010010 aaaa5555 00000000 0 000
ram_wr_b 1 00010204 0badf00d 00000000 0 000
ram_wr_c 1 000103fc cafe0001 00000000 0 000
ram_rd_c 0 000103fc 00000000 cafe0001 0 000
ram_rd_a_byte2 0 00010012 00000000 aaaa5555 0 000
ram_rd_b_byte3 0 00010207 00000000 0badf00d 0 000
led_wr 1 50000000 fffff2a5 00000000 0 2a5
led_rd 0 50000000 00000000 000002a5 0 2a5
led_rd_off4 0 50000004 00000000 00000000 0 2a5
led_wr_off8 1 50000008 ffffffff 00000000 0 2a5
unmapped_rd 0 30000000 00000000 00000000 1 2a5
unmapped_wr 1 30000000 11111111 00000000 1 2a5
after_unmapped 0 00010000 00000000 12345678 0 2a5
burst_wr0 1 00010100 a0000000 00000000 0 2a5
burst_wr1 1 00010104 a1111111 00000000 0 2a5
burst_wr2 1 00010108 a2222222 00000000 0 2a5
burst_wr3 1 0001010c a3333333 00000000 0 2a5
burst_wr4 1 00010110 a4444444 00000000 0 2a5
burst_wr5 1 00010114 a5555555 00000000 0 2a5
burst_rd3 0 0001010c 00000000 a3333333 0 2a5
burst_rd0 0 00010100 00000000 a0000000 0 2a5
burst_rd5 0 00010114 00000000 a5555555 0 2a5
burst_rd1 0 00010104 00000000 a1111111 0 2a5
burst_rd4 0 00010110 00000000 a4444444 0 2a5
burst_rd2 0 00010108 00000000 a2222222 0 2a5

/* soc_bus.f */
hdl/soc_bus_pkg.sv
hdl/cmd_fifo.sv
hdl/bus_master.sv
hdl/bus_decoder.sv
hdl/block_ram.sv
hdl/led_register.sv
hdl/soc_bus_top.sv
sim/bus_checker.sv
sim/soc_bus_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := soc_bus_tb
FILELIST  := soc_bus.f
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
STIMULUS  := sim/soc_bus_stimulus.txt
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM) $(STIMULUS)
	./$(SIM) | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then exit 1; fi
	@grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/soc_bus_tb.sv */
`default_nettype none

module soc_bus_tb
	import soc_bus_pkg::*;
();

	logic                  clock;
	logic                  i_rst_n;
	logic                  i_cmd_valid;
	logic                  i_cmd_rw;
	logic [ADDR_WIDTH-1:0] i_cmd_address;
	logic [DATA_WIDTH-1:0] i_cmd_wdata;
	logic                  o_cmd_full;
	logic                  o_rsp_valid;
	logic [DATA_WIDTH-1:0] o_rsp_rdata;
	logic                  o_rsp_error;
	logic [LED_WIDTH-1:0]  o_led;

	// Commands loaded from the stimulus file
	string                 t_name  [$];
	logic                  t_rw    [$];
	logic [ADDR_WIDTH-1:0] t_addr  [$];
	logic [DATA_WIDTH-1:0] t_wdata [$];
	logic [DATA_WIDTH-1:0] t_rdata [$];
	logic                  t_error [$];
	logic [LED_WIDTH-1:0]  t_led   [$];

	int   num_tests = 0;
	logic loaded    = 1'b0;

	soc_bus_top i_dut (
		.clock         (clock),
		.i_rst_n       (i_rst_n),
		.i_cmd_valid   (i_cmd_valid),
		.i_cmd_rw      (i_cmd_rw),
		.i_cmd_address (i_cmd_address),
		.i_cmd_wdata   (i_cmd_wdata),
		.o_cmd_full    (o_cmd_full),
		.o_rsp_valid   (o_rsp_valid),
		.o_rsp_rdata   (o_rsp_rdata),
		.o_rsp_error   (o_rsp_error),
		.o_led         (o_led)
	);

	bus_checker i_checker (
		.clock       (clock),
		.i_rst_n     (i_rst_n),
		.i_rsp_valid (o_rsp_valid),
		.i_rsp_rdata (o_rsp_rdata),
		.i_rsp_error (o_rsp_error),
		.i_led       (o_led),
		.i_cmd_full  (o_cmd_full)
	);

	always #2 clock = ~clock;

	task automatic load_stimulus();
		int                    fd;
		int                    n;
		string                 line;
		string                 name;
		logic [31:0]           rw;
		logic [31:0]           addr;
		logic [31:0]           wdata;
		logic [31:0]           rdata;
		logic [31:0]           error;
		logic [31:0]           led;
		fd = $fopen("sim/soc_bus_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the stimulus file sim/soc_bus_stimulus.txt");
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				n = $fgets(line, fd);
				// Skip blank and comment lines
				if (n > 1 && line.substr(0, 0) != "#")
				begin
					n = $sscanf(line, "%s %h %h %h %h %h %h",
						name, rw, addr, wdata, rdata, error, led);
					if (n == 7)
					begin
						t_name.push_back(name);
						t_rw.push_back(rw[0]);
						t_addr.push_back(addr);
						t_wdata.push_back(wdata);
						t_rdata.push_back(rdata);
						t_error.push_back(error[0]);
						t_led.push_back(led[LED_WIDTH-1:0]);
					end
				end
			end
			$fclose(fd);
			num_tests = t_name.size();
		end
	endtask

	// One strobe, issued only while the queue has room
	task automatic send_command(input logic rw, input logic [ADDR_WIDTH-1:0] addr,
		input logic [DATA_WIDTH-1:0] wdata);
		@(negedge clock);
		while (o_cmd_full)
			@(negedge clock);
		@(posedge clock);
		i_cmd_valid   <= 1'b1;
		i_cmd_rw      <= rw;
		i_cmd_address <= addr;
		i_cmd_wdata   <= wdata;
		@(posedge clock);
		i_cmd_valid   <= 1'b0;
	endtask

	task automatic print_counts();
		$display("Tests: %0d passed, %0d failed, %0d other errors",
			i_checker.pass_count, i_checker.fail_count, i_checker.other_count);
	endtask

	initial
	begin
		clock         = 1'b0;
		i_rst_n       = 1'b0;
		i_cmd_valid   = 1'b0;
		i_cmd_rw      = 1'b0;
		i_cmd_address = '0;
		i_cmd_wdata   = '0;
		load_stimulus();
		loaded = 1'b1;
		repeat (5) @(posedge clock);
		i_rst_n <= 1'b1;
		repeat (2) @(posedge clock);
		for (int i = 0; i < num_tests; i++)
		begin
			i_checker.add_expected(t_name[i], t_rdata[i], t_error[i], t_led[i]);
			send_command(t_rw[i], t_addr[i], t_wdata[i]);
		end
		wait (i_checker.checked == num_tests);
		repeat (4) @(posedge clock);
		i_checker.check_full_seen();
		print_counts();
		if (i_checker.fail_count == 0 && i_checker.other_count == 0 && num_tests > 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// Watchdog sized from the number of commands
	initial
	begin
		wait (loaded);
		repeat (num_tests * 20 + 100) @(posedge clock);
		$display("Timeout before all responses arrived");
		i_checker.report_missing();
		print_counts();
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/bus_checker.sv */
`default_nettype none

module bus_checker
	import soc_bus_pkg::*;
(
	input  wire logic                  clock,
	input  wire logic                  i_rst_n,
	input  wire logic                  i_rsp_valid,
	input  wire logic [DATA_WIDTH-1:0] i_rsp_rdata,
	input  wire logic                  i_rsp_error,
	input  wire logic [LED_WIDTH-1:0]  i_led,
	input  wire logic                  i_cmd_full
);

	// Expected responses in command order
	string                 exp_name  [$];
	logic [DATA_WIDTH-1:0] exp_rdata [$];
	logic                  exp_error [$];
	logic [LED_WIDTH-1:0]  exp_led   [$];

	int pass_count  = 0;
	int fail_count  = 0;
	int other_count = 0;
	int checked     = 0;
	logic full_seen = 1'b0;

	task automatic add_expected(input string name, input logic [DATA_WIDTH-1:0] rdata,
		input logic error, input logic [LED_WIDTH-1:0] led);
		exp_name.push_back(name);
		exp_rdata.push_back(rdata);
		exp_error.push_back(error);
		exp_led.push_back(led);
	endtask

	task automatic report_missing();
		while (exp_name.size() > 0)
		begin
			$display("Missing response for test %s", exp_name.pop_front());
			other_count++;
		end
	endtask

	task automatic check_full_seen();
		if (!full_seen)
		begin
			$display("The command queue never reported full during the burst");
			other_count++;
		end
	endtask

	always @(posedge clock)
	begin
		if (i_rst_n && i_cmd_full)
			full_seen = 1'b1;
	end

	always @(posedge clock)
	begin
		string                 name;
		logic [DATA_WIDTH-1:0] rdata;
		logic                  error;
		logic [LED_WIDTH-1:0]  led;
		if (i_rst_n && i_rsp_valid)
		begin
			if (exp_name.size() == 0)
			begin
				$display("A response arrived with no command outstanding");
				other_count++;
			end
			else
			begin
				name  = exp_name.pop_front();
				rdata = exp_rdata.pop_front();
				error = exp_error.pop_front();
				led   = exp_led.pop_front();
				// Response fields and LEDs all compared at once
				if (i_rsp_rdata !== rdata || i_rsp_error !== error || i_led !== led)
				begin
					$write("[ERROR] %s expected rdata=%h error=%b led=%h",
						name, rdata, error, led);
					$display(" actual rdata=%h error=%b led=%h",
						i_rsp_rdata, i_rsp_error, i_led);
					fail_count++;
				end
				else
				begin
					$display("[PASS] %s", name);
					pass_count++;
				end
				checked++;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/soc_bus_top.sv */
`default_nettype none

module soc_bus_top
	import soc_bus_pkg::*;
(
	input  wire logic                  clock,
	input  wire logic                  i_rst_n,
	input  wire logic                  i_cmd_valid,
	input  wire logic                  i_cmd_rw,
	input  wire logic [ADDR_WIDTH-1:0] i_cmd_address,
	input  wire logic [DATA_WIDTH-1:0] i_cmd_wdata,
	output logic                       o_cmd_full,
	output logic                       o_rsp_valid,
	output logic      [DATA_WIDTH-1:0] o_rsp_rdata,
	output logic                       o_rsp_error,
	output logic      [LED_WIDTH-1:0]  o_led
);

	// Queue to master
	logic                  fifo_empty;
	logic [CMD_WIDTH-1:0]  fifo_head;
	logic                  fifo_pop;

	// Master bus
	logic                  bus_request;
	logic                  bus_rw;
	logic [ADDR_WIDTH-1:0] bus_address;
	logic [DATA_WIDTH-1:0] bus_wdata;
	logic                  bus_ready;
	logic [DATA_WIDTH-1:0] bus_rdata;
	logic                  bus_error;

	// Peripheral side
	logic                  ram_request;
	logic [ADDR_WIDTH-1:0] ram_address;
	logic                  ram_ready;
	logic [DATA_WIDTH-1:0] ram_rdata;
	logic                  led_request;
	logic [ADDR_WIDTH-1:0] led_address;
	logic                  led_ready;
	logic [DATA_WIDTH-1:0] led_rdata;

	cmd_fifo u_cmd_fifo (
		.clock   (clock),
		.i_rst_n (i_rst_n),
		.i_push  (i_cmd_valid),
		.i_entry ({i_cmd_rw, i_cmd_address, i_cmd_wdata}),
		.i_pop   (fifo_pop),
		.o_head  (fifo_head),
		.o_full  (o_cmd_full),
		.o_empty (fifo_empty)
	);

	bus_master u_bus_master (
		.clock         (clock),
		.i_rst_n       (i_rst_n),
		.i_empty       (fifo_empty),
		.i_head        (fifo_head),
		.o_pop         (fifo_pop),
		.o_bus_request (bus_request),
		.o_bus_rw      (bus_rw),
		.o_bus_address (bus_address),
		.o_bus_wdata   (bus_wdata),
		.i_bus_ready   (bus_ready),
		.i_bus_rdata   (bus_rdata),
		.i_bus_error   (bus_error),
		.o_rsp_valid   (o_rsp_valid),
		.o_rsp_rdata   (o_rsp_rdata),
		.o_rsp_error   (o_rsp_error)
	);

	bus_decoder u_bus_decoder (
		.i_request     (bus_request),
		.i_rw          (bus_rw),
		.i_address     (bus_address),
		.i_wdata       (bus_wdata),
		.o_ready       (bus_ready),
		.o_rdata       (bus_rdata),
		.o_error       (bus_error),
		.o_ram_request (ram_request),
		.o_ram_address (ram_address),
		.i_ram_ready   (ram_ready),
		.i_ram_rdata   (ram_rdata),
		.o_led_request (led_request),
		.o_led_address (led_address),
		.i_led_ready   (led_ready),
		.i_led_rdata   (led_rdata)
	);

	// rw and write data are shared by all peripherals
	block_ram u_block_ram (
		.clock     (clock),
		.i_rst_n   (i_rst_n),
		.i_request (ram_request),
		.i_rw      (bus_rw),
		.i_address (ram_address),
		.i_wdata   (bus_wdata),
		.o_rdata   (ram_rdata),
		.o_ready   (ram_ready)
	);

	led_register u_led_register (
		.clock     (clock),
		.i_rst_n   (i_rst_n),
		.i_request (led_request),
		.i_rw      (bus_rw),
		.i_address (led_address),
		.i_wdata   (bus_wdata),
		.o_rdata   (led_rdata),
		.o_ready   (led_ready),
		.o_led     (o_led)
	);

endmodule

`default_nettype wire

/* hdl/led_register.sv */
`default_nettype none

module led_register
	import soc_bus_pkg::*;
(
	input  wire logic                  clock,
	input  wire logic                  i_rst_n,
	input  wire logic                  i_request,
	input  wire logic                  i_rw,
	input  wire logic [ADDR_WIDTH-1:0] i_address,
	input  wire logic [DATA_WIDTH-1:0] i_wdata,
	output logic      [DATA_WIDTH-1:0] o_rdata,
	output logic                       o_ready,
	output logic      [LED_WIDTH-1:0]  o_led
);

	logic request_d;
	logic first;
	logic at_led;

	assign first  = i_request && !request_d;
	assign at_led = (i_address == '0);

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			request_d <= 1'b0;
			o_ready   <= 1'b0;
			o_led     <= '0;
		end
		else
		begin
			request_d <= i_request;
			o_ready   <= first;
			// Only offset 0 holds the LEDs
			if (first && i_rw && at_led)
				o_led <= i_wdata[LED_WIDTH-1:0];
		end
	end

	always_ff @(posedge clock)
	begin
		if (first)
			o_rdata <= at_led ? DATA_WIDTH'(o_led) : '0;
	end

endmodule

`default_nettype wire

/* hdl/block_ram.sv */
`default_nettype none

module block_ram
	import soc_bus_pkg::*;
(
	input  wire logic                  clock,
	input  wire logic                  i_rst_n,
	input  wire logic                  i_request,
	input  wire logic                  i_rw,
	input  wire logic [ADDR_WIDTH-1:0] i_address,
	input  wire logic [DATA_WIDTH-1:0] i_wdata,
	output logic      [DATA_WIDTH-1:0] o_rdata,
	output logic                       o_ready
);

	logic [DATA_WIDTH-1:0]      mem [RAM_DEPTH];
	logic [RAM_INDEX_WIDTH-1:0] index;
	logic                       request_d;
	logic                       first;

	// Word index, byte lanes dropped
	assign index = i_address[2 +: RAM_INDEX_WIDTH];

	// Only the opening cycle of a request counts
	assign first = i_request && !request_d;

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			request_d <= 1'b0;
			o_ready   <= 1'b0;
		end
		else
		begin
			request_d <= i_request;
			o_ready   <= first;
		end
	end

	always_ff @(posedge clock)
	begin
		if (first)
		begin
			if (i_rw)
				mem[index] <= i_wdata;
			o_rdata <= mem[index];
		end
	end

	// ready only answers a request that is still held
	a_ready_in_request: assert property (@(posedge clock) disable iff (!i_rst_n)
		o_ready |-> i_request);

endmodule

`default_nettype wire

/* hdl/bus_decoder.sv */
`default_nettype none

module bus_decoder
	import soc_bus_pkg::*;
(
	input  wire logic                  i_request,
	input  wire logic                  i_rw,
	input  wire logic [ADDR_WIDTH-1:0] i_address,
	input  wire logic [DATA_WIDTH-1:0] i_wdata,
	output logic                       o_ready,
	output logic      [DATA_WIDTH-1:0] o_rdata,
	output logic                       o_error,
	output logic                       o_ram_request,
	output logic      [ADDR_WIDTH-1:0] o_ram_address,
	input  wire logic                  i_ram_ready,
	input  wire logic [DATA_WIDTH-1:0] i_ram_rdata,
	output logic                       o_led_request,
	output logic      [ADDR_WIDTH-1:0] o_led_address,
	input  wire logic                  i_led_ready,
	input  wire logic [DATA_WIDTH-1:0] i_led_rdata
);

	logic ram_select;
	logic led_select;
	logic unmapped;

	// Offset wraps below the base, so one compare covers both bounds
	assign o_ram_address = i_address - RAM_BASE;
	assign o_led_address = i_address - LED_BASE;
	assign ram_select    = (o_ram_address < RAM_SIZE);
	assign led_select    = (o_led_address < LED_SIZE);
	assign unmapped      = !ram_select && !led_select;

	assign o_ram_request = i_request && ram_select;
	assign o_led_request = i_request && led_select;

	// Unmapped accesses complete in the request cycle
	assign o_ready = ram_select ? i_ram_ready :
		led_select ? i_led_ready :
		i_request;
	assign o_error = i_request && unmapped;

	// Writes carry no read data back
	assign o_rdata = i_rw ? '0 :
		ram_select ? i_ram_rdata :
		led_select ? i_led_rdata :
		'0;

	always_comb
	begin
		// write data from the master must be settled
		if (i_request && i_rw)
			a_wdata_known: assert (!$isunknown(i_wdata));
	end

endmodule

`default_nettype wire

/* hdl/bus_master.sv */
`default_nettype none

module bus_master
	import soc_bus_pkg::*;
(
	input  wire logic                  clock,
	input  wire logic                  i_rst_n,
	input  wire logic                  i_empty,
	input  wire logic [CMD_WIDTH-1:0]  i_head,
	output logic                       o_pop,
	output logic                       o_bus_request,
	output logic                       o_bus_rw,
	output logic      [ADDR_WIDTH-1:0] o_bus_address,
	output logic      [DATA_WIDTH-1:0] o_bus_wdata,
	input  wire logic                  i_bus_ready,
	input  wire logic [DATA_WIDTH-1:0] i_bus_rdata,
	input  wire logic                  i_bus_error,
	output logic                       o_rsp_valid,
	output logic      [DATA_WIDTH-1:0] o_rsp_rdata,
	output logic                       o_rsp_error
);

	typedef enum logic {
		ST_IDLE,
		ST_BUSY
	} state_t;

	state_t state;

	// Take the head as soon as we are free
	assign o_pop = (state == ST_IDLE) && !i_empty;

	// Request is simply the busy state
	assign o_bus_request = (state == ST_BUSY);

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state       <= ST_IDLE;
			o_rsp_valid <= 1'b0;
		end
		else
		begin
			o_rsp_valid <= 1'b0;
			case (state)
				ST_IDLE:
					if (o_pop)
						state <= ST_BUSY;
				ST_BUSY:
					if (i_bus_ready)
					begin
						state       <= ST_IDLE;
						o_rsp_valid <= 1'b1;
					end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// Command fields held for the whole access
	always_ff @(posedge clock)
	begin
		if (o_pop)
		begin
			o_bus_rw      <= i_head[CMD_WIDTH-1];
			o_bus_address <= i_head[DATA_WIDTH +: ADDR_WIDTH];
			o_bus_wdata   <= i_head[DATA_WIDTH-1:0];
		end
		if (o_bus_request && i_bus_ready)
		begin
			o_rsp_rdata <= i_bus_rdata;
			o_rsp_error <= i_bus_error;
		end
	end

	// Command must not move under a pending request
	a_bus_stable: assert property (@(posedge clock) disable iff (!i_rst_n)
		o_bus_request && !i_bus_ready |=> o_bus_request && $stable(o_bus_address)
			&& $stable(o_bus_rw) && $stable(o_bus_wdata));

endmodule

`default_nettype wire

/* hdl/cmd_fifo.sv */
`default_nettype none

module cmd_fifo
	import soc_bus_pkg::*;
(
	input  wire logic                 clock,
	input  wire logic                 i_rst_n,
	input  wire logic                 i_push,
	input  wire logic [CMD_WIDTH-1:0] i_entry,
	input  wire logic                 i_pop,
	output logic      [CMD_WIDTH-1:0] o_head,
	output logic                      o_full,
	output logic                      o_empty
);

	logic [CMD_WIDTH-1:0]        entries [FIFO_DEPTH];
	logic [FIFO_PTR_WIDTH-1:0]   wr_ptr;
	logic [FIFO_PTR_WIDTH-1:0]   rd_ptr;
	logic [FIFO_COUNT_WIDTH-1:0] count;
	logic                        do_push;
	logic                        do_pop;

	assign o_full  = (count == FIFO_COUNT_WIDTH'(FIFO_DEPTH));
	assign o_empty = (count == '0);
	assign o_head  = entries[rd_ptr];

	assign do_push = i_push && !o_full;
	assign do_pop  = i_pop && !o_empty;

	always_ff @(posedge clock)
	begin
		if (do_push)
			entries[wr_ptr] <= i_entry;
	end

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			// Pointers wrap at the last slot
			if (do_push)
				wr_ptr <= (wr_ptr == FIFO_PTR_WIDTH'(FIFO_DEPTH - 1)) ?
					'0 : wr_ptr + FIFO_PTR_WIDTH'(1);
			if (do_pop)
				rd_ptr <= (rd_ptr == FIFO_PTR_WIDTH'(FIFO_DEPTH - 1)) ?
					'0 : rd_ptr + FIFO_PTR_WIDTH'(1);
			if (do_push && !do_pop)
				count <= count + FIFO_COUNT_WIDTH'(1);
			else if (do_pop && !do_push)
				count <= count - FIFO_COUNT_WIDTH'(1);
		end
	end

	// Host must hold off while the queue is full
	a_no_push_when_full: assert property (@(posedge clock) disable iff (!i_rst_n)
		o_full |-> !i_push);

	// Master only pops a valid head
	a_no_pop_when_empty: assert property (@(posedge clock) disable iff (!i_rst_n)
		o_empty |-> !i_pop);

endmodule

`default_nettype wire

/* hdl/soc_bus_pkg.sv */
`default_nettype none

package soc_bus_pkg;

	// Bus widths
	localparam int DATA_WIDTH = 32;
	localparam int ADDR_WIDTH = 32;

	// Queue entry is {rw, address, wdata}
	localparam int CMD_WIDTH = 1 + ADDR_WIDTH + DATA_WIDTH;

	// Command queue
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
	localparam int FIFO_COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

	// Block RAM, in 32-bit words
	localparam int RAM_DEPTH = 256;
	localparam int RAM_INDEX_WIDTH = $clog2(RAM_DEPTH);

	// Address map
	localparam logic [ADDR_WIDTH-1:0] RAM_BASE = 32'h0001_0000;
	localparam logic [ADDR_WIDTH-1:0] RAM_SIZE = 32'h0001_0000;
	localparam logic [ADDR_WIDTH-1:0] LED_BASE = 32'h5000_0000;
	localparam logic [ADDR_WIDTH-1:0] LED_SIZE = 32'h0000_0010;

	// Board LEDs
	localparam int LED_WIDTH = 10;

endpackage

`default_nettype wire
